//--- source/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define MIPS_XLEN       32
`define MIPS_REG_AW     5
`define MIPS_OP_W       6
`define MIPS_IMM_W      16
`define MIPS_LINK_REG   5'd31
`define MIPS_RESET_PC   32'h0000_0000

// opcodes
`define MIPS_OP_RTYPE   6'h00
`define MIPS_OP_J       6'h02
`define MIPS_OP_JAL     6'h03
`define MIPS_OP_BEQ     6'h04
`define MIPS_OP_BNE     6'h05
`define MIPS_OP_ADDI    6'h08
`define MIPS_OP_ADDIU   6'h09
`define MIPS_OP_SLTI    6'h0a
`define MIPS_OP_SLTIU   6'h0b
`define MIPS_OP_ANDI    6'h0c
`define MIPS_OP_ORI     6'h0d
`define MIPS_OP_XORI    6'h0e
`define MIPS_OP_LUI     6'h0f
`define MIPS_OP_LW      6'h23
`define MIPS_OP_SW      6'h2b

// function codes for R-type
`define MIPS_FN_ADD     6'h20
`define MIPS_FN_ADDU    6'h21
`define MIPS_FN_SUB     6'h22
`define MIPS_FN_SUBU    6'h23
`define MIPS_FN_AND     6'h24
`define MIPS_FN_OR      6'h25
`define MIPS_FN_XOR     6'h26
`define MIPS_FN_NOR     6'h27
`define MIPS_FN_SLT     6'h2a
`define MIPS_FN_SLTU    6'h2b

// FSM states
`define MIPS_ST_W         4
`define MIPS_ST_FETCH     4'd0
`define MIPS_ST_DECODE    4'd1
`define MIPS_ST_ALU_EXE   4'd2
`define MIPS_ST_ALU_WR_RF 4'd3
`define MIPS_ST_DM_EXE    4'd4
`define MIPS_ST_DM_SW     4'd5
`define MIPS_ST_DM_LW     4'd6
`define MIPS_ST_DM_WR_RF  4'd7
`define MIPS_ST_BTYPE_EXE 4'd8
`define MIPS_ST_LUI_WR_RF 4'd9
`define MIPS_ST_JAL_EXE   4'd10

// ALU operations
`define MIPS_ALU_ADD    4'd0
`define MIPS_ALU_SUB    4'd1
`define MIPS_ALU_OR     4'd2
`define MIPS_ALU_SLT    4'd3
`define MIPS_ALU_SLTU   4'd4
`define MIPS_ALU_AND    4'd5
`define MIPS_ALU_NOR    4'd6
`define MIPS_ALU_XOR    4'd7

// write-back data, write-back address and next-pc selects
`define MIPS_WB_ALU     2'd0
`define MIPS_WB_MEM     2'd1
`define MIPS_WB_PC      2'd2
`define MIPS_WB_IMM     2'd3
`define MIPS_RD_RD      2'd0
`define MIPS_RD_RT      2'd1
`define MIPS_RD_LINK    2'd2
`define MIPS_NPC_SEQ    2'd0
`define MIPS_NPC_BRANCH 2'd1
`define MIPS_NPC_JUMP   2'd2

`endif

//--- source/mips_pkg.sv
`include "mips_defs.svh"

package mips_pkg;

    typedef struct packed {
        logic [`MIPS_OP_W-1:0]   opcode;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [`MIPS_REG_AW-1:0] shamt;
        logic [`MIPS_OP_W-1:0]   funct;
    } r_fields_t;

    typedef struct packed {
        logic [`MIPS_OP_W-1:0]   opcode;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_IMM_W-1:0]  imm;
    } i_fields_t;

    // one instruction word, seen as R-format, I-format or raw bits
    typedef union packed {
        r_fields_t              r;
        i_fields_t              i;
        logic [`MIPS_XLEN-1:0]  raw;
    } instr_u;

endpackage

//--- source/mips_alu.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_alu (
    input  logic [`MIPS_XLEN-1:0] a,
    input  logic [`MIPS_XLEN-1:0] b,
    input  logic [3:0]            alu_op,
    output logic [`MIPS_XLEN-1:0] result,
    output logic                  zero,
    output logic                  ovf
);

    logic [`MIPS_XLEN-1:0] sum;
    logic [`MIPS_XLEN-1:0] diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (alu_op)
            `MIPS_ALU_ADD:  result = sum;
            `MIPS_ALU_SUB:  result = diff;
            `MIPS_ALU_OR:   result = a | b;
            `MIPS_ALU_SLT:  result = {{(`MIPS_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            `MIPS_ALU_SLTU: result = {{(`MIPS_XLEN-1){1'b0}}, a < b};
            `MIPS_ALU_AND:  result = a & b;
            `MIPS_ALU_NOR:  result = ~(a | b);
            `MIPS_ALU_XOR:  result = a ^ b;
            default:        result = '0;
        endcase
    end

    // signed overflow, operand signs against result sign
    always_comb begin
        case (alu_op)
            `MIPS_ALU_ADD: ovf = (a[`MIPS_XLEN-1] == b[`MIPS_XLEN-1])
                              && (sum[`MIPS_XLEN-1] != a[`MIPS_XLEN-1]);
            `MIPS_ALU_SUB: ovf = (a[`MIPS_XLEN-1] != b[`MIPS_XLEN-1])
                              && (diff[`MIPS_XLEN-1] != a[`MIPS_XLEN-1]);
            default:       ovf = 1'b0;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- source/mips_regfile.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`MIPS_REG_AW-1:0] rs_addr,
    input  logic [`MIPS_REG_AW-1:0] rt_addr,
    output logic [`MIPS_XLEN-1:0]   rs_data,
    output logic [`MIPS_XLEN-1:0]   rt_data,
    input  logic                    wr_en,
    input  logic [`MIPS_REG_AW-1:0] wr_addr,
    input  logic [`MIPS_XLEN-1:0]   wr_data
);

    logic [`MIPS_XLEN-1:0] regs [0:(2**`MIPS_REG_AW)-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**`MIPS_REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // $zero always reads as zero
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

//--- source/mips_control.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_control (
    input  logic                 clk,
    input  logic                 rst,
    input  mips_pkg::instr_u     instr,
    input  logic                 alu_zero,
    input  logic                 alu_ovf,
    output logic                 ir_wr,
    output logic                 pc_wr,
    output logic                 rf_wr,
    output logic                 dmem_we,
    output logic [3:0]           alu_op,
    output logic                 alu_src_imm,
    output logic                 ext_sign,
    output logic [1:0]           wb_sel,
    output logic [1:0]           rd_sel,
    output logic [1:0]           npc_sel,
    output logic                 integer_overflow
);

    logic [`MIPS_ST_W-1:0] state;
    logic [`MIPS_ST_W-1:0] state_nxt;
    logic [`MIPS_OP_W-1:0] opcode;
    logic [`MIPS_OP_W-1:0] funct;
    logic fn_ok;
    logic is_ralu;
    logic is_ialu;
    logic is_lui;
    logic is_lw;
    logic is_sw;
    logic is_beq;
    logic is_bne;
    logic is_j;
    logic is_jal;
    logic unsupported;
    logic ovf_check;
    logic br_taken;

    assign opcode = instr.i.opcode;
    assign funct  = instr.r.funct;

    always_comb begin
        case (funct)
            `MIPS_FN_ADD, `MIPS_FN_ADDU, `MIPS_FN_SUB, `MIPS_FN_SUBU,
            `MIPS_FN_SLT, `MIPS_FN_SLTU, `MIPS_FN_AND, `MIPS_FN_OR,
            `MIPS_FN_XOR, `MIPS_FN_NOR: fn_ok = 1'b1;
            default:                    fn_ok = 1'b0;
        endcase
    end

    assign is_ralu = (opcode == `MIPS_OP_RTYPE) && fn_ok && (instr.r.shamt == '0);
    assign is_ialu = opcode inside {`MIPS_OP_ADDI, `MIPS_OP_ADDIU, `MIPS_OP_SLTI,
                                    `MIPS_OP_SLTIU, `MIPS_OP_ANDI, `MIPS_OP_ORI,
                                    `MIPS_OP_XORI};
    assign is_lui  = (opcode == `MIPS_OP_LUI);
    assign is_lw   = (opcode == `MIPS_OP_LW);
    assign is_sw   = (opcode == `MIPS_OP_SW);
    assign is_beq  = (opcode == `MIPS_OP_BEQ);
    assign is_bne  = (opcode == `MIPS_OP_BNE);
    assign is_j    = (opcode == `MIPS_OP_J);
    assign is_jal  = (opcode == `MIPS_OP_JAL);

    assign unsupported = !(is_ralu || is_ialu || is_lui || is_lw || is_sw
                           || is_beq || is_bne || is_j || is_jal);

    // only add, addi and sub raise the overflow flag
    assign ovf_check = (is_ralu && (funct == `MIPS_FN_ADD || funct == `MIPS_FN_SUB))
                       || (opcode == `MIPS_OP_ADDI);

    always_comb begin
        if (opcode == `MIPS_OP_RTYPE) begin
            case (funct)
                `MIPS_FN_SUB, `MIPS_FN_SUBU: alu_op = `MIPS_ALU_SUB;
                `MIPS_FN_SLT:                alu_op = `MIPS_ALU_SLT;
                `MIPS_FN_SLTU:               alu_op = `MIPS_ALU_SLTU;
                `MIPS_FN_AND:                alu_op = `MIPS_ALU_AND;
                `MIPS_FN_OR:                 alu_op = `MIPS_ALU_OR;
                `MIPS_FN_XOR:                alu_op = `MIPS_ALU_XOR;
                `MIPS_FN_NOR:                alu_op = `MIPS_ALU_NOR;
                default:                     alu_op = `MIPS_ALU_ADD;
            endcase
        end else begin
            case (opcode)
                `MIPS_OP_SLTI:               alu_op = `MIPS_ALU_SLT;
                `MIPS_OP_SLTIU:              alu_op = `MIPS_ALU_SLTU;
                `MIPS_OP_ANDI:               alu_op = `MIPS_ALU_AND;
                `MIPS_OP_ORI:                alu_op = `MIPS_ALU_OR;
                `MIPS_OP_XORI:               alu_op = `MIPS_ALU_XOR;
                `MIPS_OP_BEQ, `MIPS_OP_BNE:  alu_op = `MIPS_ALU_SUB;
                default:                     alu_op = `MIPS_ALU_ADD;
            endcase
        end
    end

    assign alu_src_imm = is_ialu || is_lw || is_sw;
    // logical immediates are zero extended
    assign ext_sign = !(opcode == `MIPS_OP_ANDI || opcode == `MIPS_OP_ORI
                        || opcode == `MIPS_OP_XORI);

    always_comb begin
        case (state)
            `MIPS_ST_FETCH:   state_nxt = `MIPS_ST_DECODE;
            `MIPS_ST_DECODE: begin
                if (is_ralu || is_ialu) begin
                    state_nxt = `MIPS_ST_ALU_EXE;
                end else if (is_lui) begin
                    state_nxt = `MIPS_ST_LUI_WR_RF;
                end else if (is_lw || is_sw) begin
                    state_nxt = `MIPS_ST_DM_EXE;
                end else if (is_beq || is_bne) begin
                    state_nxt = `MIPS_ST_BTYPE_EXE;
                end else if (is_j || is_jal) begin
                    state_nxt = `MIPS_ST_JAL_EXE;
                end else begin
                    state_nxt = `MIPS_ST_FETCH;
                end
            end
            `MIPS_ST_ALU_EXE: state_nxt = `MIPS_ST_ALU_WR_RF;
            `MIPS_ST_DM_EXE:  state_nxt = is_sw ? `MIPS_ST_DM_SW : `MIPS_ST_DM_LW;
            `MIPS_ST_DM_LW:   state_nxt = `MIPS_ST_DM_WR_RF;
            default:          state_nxt = `MIPS_ST_FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= `MIPS_ST_FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    assign br_taken = (is_beq && alu_zero) || (is_bne && !alu_zero);

    assign ir_wr   = (state == `MIPS_ST_FETCH);
    assign dmem_we = (state == `MIPS_ST_DM_SW);
    assign rf_wr   = (state == `MIPS_ST_ALU_WR_RF) || (state == `MIPS_ST_LUI_WR_RF)
                     || (state == `MIPS_ST_DM_WR_RF) || (state == `MIPS_ST_JAL_EXE && is_jal);
    // pc moves on in the last state of every instruction
    assign pc_wr   = (state == `MIPS_ST_ALU_WR_RF) || (state == `MIPS_ST_LUI_WR_RF)
                     || (state == `MIPS_ST_DM_WR_RF) || (state == `MIPS_ST_DM_SW)
                     || (state == `MIPS_ST_BTYPE_EXE) || (state == `MIPS_ST_JAL_EXE)
                     || (state == `MIPS_ST_DECODE && unsupported);

    always_comb begin
        case (state)
            `MIPS_ST_DM_WR_RF:  wb_sel = `MIPS_WB_MEM;
            `MIPS_ST_LUI_WR_RF: wb_sel = `MIPS_WB_IMM;
            `MIPS_ST_JAL_EXE:   wb_sel = `MIPS_WB_PC;
            default:            wb_sel = `MIPS_WB_ALU;
        endcase
    end

    always_comb begin
        if (state == `MIPS_ST_JAL_EXE) begin
            rd_sel = `MIPS_RD_LINK;
        end else if (is_ralu) begin
            rd_sel = `MIPS_RD_RD;
        end else begin
            rd_sel = `MIPS_RD_RT;
        end
    end

    always_comb begin
        if (state == `MIPS_ST_BTYPE_EXE && br_taken) begin
            npc_sel = `MIPS_NPC_BRANCH;
        end else if (state == `MIPS_ST_JAL_EXE) begin
            npc_sel = `MIPS_NPC_JUMP;
        end else begin
            npc_sel = `MIPS_NPC_SEQ;
        end
    end

    // flag shows up during the write-back cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            integer_overflow <= 1'b0;
        end else begin
            integer_overflow <= (state == `MIPS_ST_ALU_EXE) && ovf_check && alu_ovf;
        end
    end

endmodule

//--- source/mips_datapath.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_datapath (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ir_wr,
    input  logic                  pc_wr,
    input  logic                  rf_wr,
    input  logic [3:0]            alu_op,
    input  logic                  alu_src_imm,
    input  logic                  ext_sign,
    input  logic [1:0]            wb_sel,
    input  logic [1:0]            rd_sel,
    input  logic [1:0]            npc_sel,
    output logic                  alu_ovf,
    output mips_pkg::instr_u      instr,
    output logic                  alu_zero,
    output logic [`MIPS_XLEN-1:0] imem_addr,
    input  logic [`MIPS_XLEN-1:0] imem_data,
    output logic [`MIPS_XLEN-1:0] dmem_addr,
    output logic [`MIPS_XLEN-1:0] dmem_wdata,
    input  logic [`MIPS_XLEN-1:0] dmem_rdata
);

    mips_pkg::instr_u        ir;
    logic [`MIPS_XLEN-1:0]   pc;
    logic [`MIPS_XLEN-1:0]   pc_plus4;
    logic [`MIPS_XLEN-1:0]   npc;
    logic [`MIPS_XLEN-1:0]   imm_ext;
    logic [`MIPS_XLEN-1:0]   lui_val;
    logic [`MIPS_XLEN-1:0]   rs_data;
    logic [`MIPS_XLEN-1:0]   rt_data;
    logic [`MIPS_XLEN-1:0]   opa_q;
    logic [`MIPS_XLEN-1:0]   opb_q;
    logic [`MIPS_XLEN-1:0]   alu_b;
    logic [`MIPS_XLEN-1:0]   alu_res;
    logic [`MIPS_XLEN-1:0]   alu_q;
    logic [`MIPS_XLEN-1:0]   mem_q;
    logic [`MIPS_REG_AW-1:0] wr_addr;
    logic [`MIPS_XLEN-1:0]   wr_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `MIPS_RESET_PC;
        end else if (pc_wr) begin
            pc <= npc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ir.raw <= '0;
        end else if (ir_wr) begin
            ir.raw <= imem_data;
        end
    end

    assign imem_addr = pc;
    assign instr     = ir;
    assign pc_plus4  = pc + `MIPS_XLEN'(4);

    assign imm_ext = ext_sign ? {{(`MIPS_XLEN-`MIPS_IMM_W){ir.i.imm[`MIPS_IMM_W-1]}}, ir.i.imm}
                              : {{(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}, ir.i.imm};
    assign lui_val = {ir.i.imm, {(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}};

    always_comb begin
        case (npc_sel)
            `MIPS_NPC_BRANCH: npc = pc_plus4 + {imm_ext[`MIPS_XLEN-3:0], 2'b00};
            // jump keeps the top nibble of pc plus 4
            `MIPS_NPC_JUMP:   npc = {pc_plus4[`MIPS_XLEN-1:28], ir.raw[25:0], 2'b00};
            default:          npc = pc_plus4;
        endcase
    end

    mips_regfile regfile_i (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (ir.r.rs),
        .rt_addr (ir.r.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (rf_wr),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    // operand and result latches, refreshed every cycle
    always_ff @(posedge clk) begin
        opa_q <= rs_data;
        opb_q <= rt_data;
        alu_q <= alu_res;
        mem_q <= dmem_rdata;
    end

    assign alu_b = alu_src_imm ? imm_ext : opb_q;

    mips_alu alu_i (
        .a      (opa_q),
        .b      (alu_b),
        .alu_op (alu_op),
        .result (alu_res),
        .zero   (alu_zero),
        .ovf    (alu_ovf)
    );

    always_comb begin
        case (rd_sel)
            `MIPS_RD_RD:   wr_addr = ir.r.rd;
            `MIPS_RD_LINK: wr_addr = `MIPS_LINK_REG;
            default:       wr_addr = ir.i.rt;
        endcase
    end

    always_comb begin
        case (wb_sel)
            `MIPS_WB_MEM: wr_data = mem_q;
            `MIPS_WB_PC:  wr_data = pc_plus4;
            `MIPS_WB_IMM: wr_data = lui_val;
            default:      wr_data = alu_q;
        endcase
    end

    assign dmem_addr  = alu_q;
    assign dmem_wdata = opb_q;

endmodule

//--- source/mips_core.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_core (
    input  logic                  clk,
    input  logic                  rst,
    output logic [`MIPS_XLEN-1:0] imem_addr,
    input  logic [`MIPS_XLEN-1:0] imem_data,
    output logic [`MIPS_XLEN-1:0] dmem_addr,
    output logic [`MIPS_XLEN-1:0] dmem_wdata,
    output logic                  dmem_we,
    input  logic [`MIPS_XLEN-1:0] dmem_rdata,
    output logic                  integer_overflow
);

    mips_pkg::instr_u instr;
    logic             alu_zero;
    logic             alu_ovf;
    logic             ir_wr;
    logic             pc_wr;
    logic             rf_wr;
    logic [3:0]       alu_op;
    logic             alu_src_imm;
    logic             ext_sign;
    logic [1:0]       wb_sel;
    logic [1:0]       rd_sel;
    logic [1:0]       npc_sel;

    mips_control control_i (
        .clk              (clk),
        .rst              (rst),
        .instr            (instr),
        .alu_zero         (alu_zero),
        .alu_ovf          (alu_ovf),
        .ir_wr            (ir_wr),
        .pc_wr            (pc_wr),
        .rf_wr            (rf_wr),
        .dmem_we          (dmem_we),
        .alu_op           (alu_op),
        .alu_src_imm      (alu_src_imm),
        .ext_sign         (ext_sign),
        .wb_sel           (wb_sel),
        .rd_sel           (rd_sel),
        .npc_sel          (npc_sel),
        .integer_overflow (integer_overflow)
    );

    mips_datapath datapath_i (
        .clk         (clk),
        .rst         (rst),
        .ir_wr       (ir_wr),
        .pc_wr       (pc_wr),
        .rf_wr       (rf_wr),
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .ext_sign    (ext_sign),
        .wb_sel      (wb_sel),
        .rd_sel      (rd_sel),
        .npc_sel     (npc_sel),
        .alu_ovf     (alu_ovf),
        .instr       (instr),
        .alu_zero    (alu_zero),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_rdata  (dmem_rdata)
    );

endmodule

//--- test/mips_core_tb.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_core_tb;

    localparam int CLK_PERIOD = 40;
    localparam int PROG_MAX   = 64;
    localparam int RUNS       = 12;
    localparam logic [31:0] DONE_ADDR = 32'h0000_03fc;
    localparam logic [31:0] RES_BASE  = 32'h0000_0100;

    logic        clk;
    logic        rst;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;
    logic        integer_overflow;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] prog [$];
    logic [31:0] lfsr_q;
    int          errors;
    int          checks;
    int          ovf_cycles;

    mips_core dut_i (
        .clk              (clk),
        .rst              (rst),
        .imem_addr        (imem_addr),
        .imem_data        (imem_data),
        .dmem_addr        (dmem_addr),
        .dmem_wdata       (dmem_wdata),
        .dmem_we          (dmem_we),
        .dmem_rdata       (dmem_rdata),
        .integer_overflow (integer_overflow)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // word-addressed memory models
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    always @(negedge clk) begin
        if (!rst && integer_overflow) begin
            ovf_cycles++;
        end
    end

    initial begin
        #(RUNS * (PROG_MAX * 5 + 204) * CLK_PERIOD);
        $display("watchdog expired before all tests completed");
        $display("Verification failed");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic mips_pkg::instr_u r_word(logic [5:0] fn, logic [4:0] rd,
                                                logic [4:0] rs, logic [4:0] rt);
        mips_pkg::instr_u w;
        w.raw     = '0;
        w.r.opcode = `MIPS_OP_RTYPE;
        w.r.rs    = rs;
        w.r.rt    = rt;
        w.r.rd    = rd;
        w.r.funct = fn;
        return w;
    endfunction

    function automatic mips_pkg::instr_u i_word(logic [5:0] op, logic [4:0] rt,
                                                logic [4:0] rs, logic [15:0] imm);
        mips_pkg::instr_u w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic mips_pkg::instr_u j_word(logic [5:0] op, int idx);
        mips_pkg::instr_u w;
        w.raw = {op, 26'(idx)};
        return w;
    endfunction

    task automatic emit(input mips_pkg::instr_u w);
        prog.push_back(w.raw);
    endtask

    // marker store, then spin on a jump to itself
    task automatic finish_program();
        emit(i_word(`MIPS_OP_ORI, 30, 0, 16'h0d0e));
        emit(i_word(`MIPS_OP_SW, 30, 0, DONE_ADDR[15:0]));
        emit(j_word(`MIPS_OP_J, prog.size()));
    endtask

    // expected results from the instruction set rules
    function automatic logic [31:0] expect_rr(logic [5:0] fn, logic [31:0] a, logic [31:0] b);
        case (fn)
            `MIPS_FN_ADD, `MIPS_FN_ADDU: return a + b;
            `MIPS_FN_SUB, `MIPS_FN_SUBU: return a - b;
            `MIPS_FN_AND:                return a & b;
            `MIPS_FN_OR:                 return a | b;
            `MIPS_FN_XOR:                return a ^ b;
            `MIPS_FN_NOR:                return ~(a | b);
            `MIPS_FN_SLT:                return {31'b0, $signed(a) < $signed(b)};
            `MIPS_FN_SLTU:               return {31'b0, a < b};
            default:                     return '0;
        endcase
    endfunction

    function automatic logic [31:0] expect_imm(logic [5:0] op, logic [31:0] a, logic [15:0] imm);
        logic [31:0] se;
        logic [31:0] ze;
        se = {{16{imm[15]}}, imm};
        ze = {16'h0000, imm};
        case (op)
            `MIPS_OP_ADDI, `MIPS_OP_ADDIU: return a + se;
            `MIPS_OP_SLTI:                 return {31'b0, $signed(a) < $signed(se)};
            `MIPS_OP_SLTIU:                return {31'b0, a < se};
            `MIPS_OP_ANDI:                 return a & ze;
            `MIPS_OP_ORI:                  return a | ze;
            `MIPS_OP_XORI:                 return a ^ ze;
            default:                       return '0;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [`MIPS_XLEN-1:0] got,
                              input logic [`MIPS_XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_mem(input string what, input logic [31:0] addr,
                             input logic [31:0] exp);
        check_word($sformatf("dmem[0x%03h] %s", addr, what), dmem[addr[9:2]], exp);
    endtask

    // background word, distinct for every data address
    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return 32'h5a5a_0000 ^ ~addr;
    endfunction

    task automatic fill_data();
        for (int k = 0; k < 256; k++) begin
            dmem[k] = fill_word(32'(4 * k));
        end
    endtask

    task automatic run_program();
        int limit;
        int cyc;
        bit done;
        limit = prog.size() * 5 + 200;
        cyc   = 0;
        done  = 0;
        @(posedge clk);
        #5;
        rst = 1'b1;
        for (int k = 0; k < 256; k++) begin
            imem[k] = (k < prog.size()) ? prog[k] : '0;
        end
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;
        ovf_cycles = 0;
        while (!done && cyc < limit) begin
            @(negedge clk);
            cyc++;
            if (dmem_we && dmem_addr == DONE_ADDR) begin
                done = 1;
            end
        end
        if (done) begin
            // let the final store land
            @(posedge clk);
            #5;
        end else begin
            errors++;
            $display("program did not reach its final store within %0d cycles", limit);
        end
    endtask

    task automatic alu_reg_test();
        logic [5:0]  fns [10] = '{`MIPS_FN_ADD, `MIPS_FN_ADDU, `MIPS_FN_SUB, `MIPS_FN_SUBU,
                                  `MIPS_FN_SLT, `MIPS_FN_SLTU, `MIPS_FN_AND, `MIPS_FN_OR,
                                  `MIPS_FN_XOR, `MIPS_FN_NOR};
        logic [31:0] a;
        logic [31:0] b;
        for (int it = 0; it < 3; it++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            prog.delete();
            emit(i_word(`MIPS_OP_LW, 1, 0, 16'h0000));
            emit(i_word(`MIPS_OP_LW, 2, 0, 16'h0004));
            for (int k = 0; k < 10; k++) begin
                emit(r_word(fns[k], 3, 1, 2));
                emit(i_word(`MIPS_OP_SW, 3, 0, 16'h0100 + 16'(4 * k)));
            end
            finish_program();
            fill_data();
            dmem[0] = a;
            dmem[1] = b;
            run_program();
            for (int k = 0; k < 10; k++) begin
                check_mem($sformatf("funct %h", fns[k]), RES_BASE + 4 * k,
                          expect_rr(fns[k], a, b));
            end
        end
    endtask

    task automatic imm_test();
        logic [5:0]  ops [7] = '{`MIPS_OP_ADDI, `MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_SLTIU,
                                 `MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI};
        logic [15:0] imms [7];
        logic [31:0] a;
        logic [15:0] hi;
        logic [15:0] lo;
        a  = rand_bits(32);
        hi = 16'(rand_bits(16));
        lo = 16'(rand_bits(16));
        prog.delete();
        emit(i_word(`MIPS_OP_LW, 1, 0, 16'h0000));
        for (int k = 0; k < 7; k++) begin
            imms[k] = 16'(rand_bits(16));
            emit(i_word(ops[k], 3, 1, imms[k]));
            emit(i_word(`MIPS_OP_SW, 3, 0, 16'h0100 + 16'(4 * k)));
        end
        // full constant from lui and ori
        emit(i_word(`MIPS_OP_LUI, 4, 0, hi));
        emit(i_word(`MIPS_OP_ORI, 4, 4, lo));
        emit(i_word(`MIPS_OP_SW, 4, 0, 16'h0140));
        finish_program();
        fill_data();
        dmem[0] = a;
        run_program();
        for (int k = 0; k < 7; k++) begin
            check_mem($sformatf("opcode %h", ops[k]), RES_BASE + 4 * k,
                      expect_imm(ops[k], a, imms[k]));
        end
        check_mem("lui/ori", 32'h0000_0140, {hi, lo});
    endtask

    task automatic load_store_test();
        logic [31:0] w [4];
        prog.delete();
        for (int k = 0; k < 4; k++) begin
            emit(i_word(`MIPS_OP_LW, 5'(5 + k), 0, 16'(4 * k)));
        end
        emit(i_word(`MIPS_OP_ADDI, 10, 0, 16'h0200));
        for (int k = 0; k < 4; k++) begin
            emit(i_word(`MIPS_OP_SW, 5'(5 + k), 10, 16'(4 * k)));
        end
        for (int k = 0; k < 4; k++) begin
            emit(i_word(`MIPS_OP_LW, 5'(11 + k), 10, 16'(4 * k)));
        end
        for (int k = 0; k < 4; k++) begin
            emit(i_word(`MIPS_OP_SW, 5'(11 + k), 10, 16'h0080 + 16'(4 * k)));
        end
        // $zero must ignore the load
        emit(i_word(`MIPS_OP_LW, 0, 0, 16'h0000));
        emit(i_word(`MIPS_OP_SW, 0, 0, 16'h0300));
        finish_program();
        fill_data();
        for (int k = 0; k < 4; k++) begin
            w[k]    = rand_bits(32);
            dmem[k] = w[k];
        end
        run_program();
        for (int k = 0; k < 4; k++) begin
            check_mem("first store", 32'h0000_0200 + 4 * k, w[k]);
            check_mem("reload and store", 32'h0000_0280 + 4 * k, w[k]);
        end
        check_mem("register zero", 32'h0000_0300, 32'h0000_0000);
    endtask

    task automatic branch_test();
        int jal_idx;
        prog.delete();
        emit(i_word(`MIPS_OP_ADDI, 1, 0, 16'd7));
        emit(i_word(`MIPS_OP_ADDI, 2, 0, 16'd7));
        emit(i_word(`MIPS_OP_ADDI, 3, 0, 16'd9));
        emit(i_word(`MIPS_OP_ORI, 20, 0, 16'h0bad));
        emit(i_word(`MIPS_OP_BEQ, 2, 1, 16'd1));
        emit(i_word(`MIPS_OP_SW, 20, 0, 16'h0100));
        emit(i_word(`MIPS_OP_SW, 1, 0, 16'h0104));
        emit(i_word(`MIPS_OP_BEQ, 3, 1, 16'd1));
        emit(i_word(`MIPS_OP_SW, 20, 0, 16'h0108));
        emit(i_word(`MIPS_OP_BNE, 3, 1, 16'd1));
        emit(i_word(`MIPS_OP_SW, 20, 0, 16'h010c));
        emit(i_word(`MIPS_OP_BNE, 2, 1, 16'd1));
        emit(i_word(`MIPS_OP_SW, 20, 0, 16'h0110));
        emit(j_word(`MIPS_OP_J, prog.size() + 2));
        emit(i_word(`MIPS_OP_SW, 20, 0, 16'h0114));
        jal_idx = prog.size();
        emit(j_word(`MIPS_OP_JAL, jal_idx + 2));
        emit(i_word(`MIPS_OP_SW, 20, 0, 16'h0118));
        emit(i_word(`MIPS_OP_SW, 31, 0, 16'h011c));
        finish_program();
        fill_data();
        run_program();
        check_mem("beq taken skips", 32'h0000_0100, fill_word(32'h0000_0100));
        check_mem("after beq", 32'h0000_0104, 32'h0000_0007);
        check_mem("beq not taken", 32'h0000_0108, 32'h0000_0bad);
        check_mem("bne taken skips", 32'h0000_010c, fill_word(32'h0000_010c));
        check_mem("bne not taken", 32'h0000_0110, 32'h0000_0bad);
        check_mem("j skips", 32'h0000_0114, fill_word(32'h0000_0114));
        check_mem("jal skips", 32'h0000_0118, fill_word(32'h0000_0118));
        check_mem("jal link", 32'h0000_011c, 32'(jal_idx * 4 + 4));
    endtask

    task automatic overflow_case(input string what, input mips_pkg::instr_u op_word,
                                 input logic [31:0] a, input logic [31:0] b,
                                 input logic [31:0] exp_res, input logic exp_ovf);
        prog.delete();
        emit(i_word(`MIPS_OP_LW, 1, 0, 16'h0000));
        emit(i_word(`MIPS_OP_LW, 2, 0, 16'h0004));
        emit(op_word);
        emit(i_word(`MIPS_OP_SW, 3, 0, 16'h0100));
        finish_program();
        fill_data();
        dmem[0] = a;
        dmem[1] = b;
        run_program();
        check_mem(what, RES_BASE, exp_res);
        check_flag($sformatf("integer_overflow %s", what), ovf_cycles != 0, exp_ovf);
    endtask

    task automatic overflow_test();
        overflow_case("add", r_word(`MIPS_FN_ADD, 3, 1, 2),
                      32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, 1'b1);
        overflow_case("addi", i_word(`MIPS_OP_ADDI, 3, 1, 16'h0001),
                      32'h7fff_ffff, 32'h0000_0000, 32'h8000_0000, 1'b1);
        overflow_case("sub", r_word(`MIPS_FN_SUB, 3, 1, 2),
                      32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, 1'b1);
        overflow_case("addu", r_word(`MIPS_FN_ADDU, 3, 1, 2),
                      32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, 1'b0);
        overflow_case("addiu", i_word(`MIPS_OP_ADDIU, 3, 1, 16'h0001),
                      32'h7fff_ffff, 32'h0000_0000, 32'h8000_0000, 1'b0);
        overflow_case("add small", r_word(`MIPS_FN_ADD, 3, 1, 2),
                      32'h0000_0001, 32'h0000_0002, 32'h0000_0003, 1'b0);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        lfsr_q     = 32'd73544;
        errors     = 0;
        checks     = 0;
        ovf_cycles = 0;
        alu_reg_test();
        imm_test();
        load_store_test();
        branch_test();
        overflow_test();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- mips_core.f
+incdir+source
source/mips_pkg.sv
source/mips_alu.sv
source/mips_regfile.sv
source/mips_control.sv
source/mips_datapath.sv
source/mips_core.sv
test/mips_core_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and decide from the simulation log
rm -f sim.log
verilator --binary --timing --top-module mips_core_tb -f mips_core.f -o mips_core_sim \
    && ./obj_dir/mips_core_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "^Verification passed$" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
